// File: Bender.yml
package:
  name: framebuffer_scanout

sources:
  - target: rtl
    files:
      - rtl/video_timing_pkg.sv
      - rtl/pixel_pkg.sv
      - rtl/raster_if.sv
      - rtl/video_ctrl_if.sv
      - rtl/raster_counter.sv
      - rtl/fb_address_gen.sv
      - rtl/sync_gen.sv
      - rtl/scanline_shader.sv
      - rtl/framebuffer_scanout.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_framebuffer_scanout.sv

// File: dv/scanout_expect.svh
/*
 * reference model of the scan-out engine
 * expected address, pixel and sync levels for one raster position
 */
`ifndef SCANOUT_EXPECT_SVH
`define SCANOUT_EXPECT_SVH

// position n in raster order, x runs fastest
function automatic int raster_x(input int n);
    return n % H_TOTAL;
endfunction

function automatic int raster_y(input int n);
    return (n / H_TOTAL) % V_TOTAL;
endfunction

function automatic bit in_draw(input int x, input int y);
    return (x < H_VISIBLE) && (y < V_VISIBLE);
endfunction

// one source word covers a 2x2 block of the screen
function automatic int expect_addr(input int x, input int y);
    if (!in_draw(x, y)) begin
        return 0;
    end
    return (y / LINE_REPEAT) * SRC_WIDTH + x / PIXEL_REPEAT;
endfunction

function automatic bit expect_hsync(input int x);
    return (x >= H_SYNC_START && x < H_SYNC_START + H_SYNC_WIDTH) ? HSYNC_ON : !HSYNC_ON;
endfunction

function automatic bit expect_vsync(input int y);
    return (y >= V_SYNC_START && y < V_SYNC_START + V_SYNC_WIDTH) ? VSYNC_ON : !VSYNC_ON;
endfunction

function automatic logic [PIXEL_W-1:0] expect_pixel(input logic [PIXEL_W-1:0] word,
        input int x, input int y, input int enable, input int odd, input int intensity);
    logic [PIXEL_W-1:0] pixel;
    pixel = word;
    if (!in_draw(x, y)) begin
        pixel = '0;
    end else if (enable != 0 && (y % 2) == odd) begin
        // halve each channel once per intensity step
        for (int c = 0; c < PIXEL_W / CHANNEL_W; c++) begin
            pixel[c*CHANNEL_W +: CHANNEL_W] =
                CHANNEL_W'(word[c*CHANNEL_W +: CHANNEL_W] / (1 << intensity));
        end
    end
    return pixel;
endfunction

`endif

// File: dv/tb_framebuffer_scanout.sv
/*
 * testbench for the framebuffer scan-out engine
 * ram model plus a table of scanline settings, with per-cycle checks of
 * address, pixel and sync outputs against the reference functions
 */
`timescale 1ns/1ps

module tb_framebuffer_scanout;
    import video_timing_pkg::*;
    import pixel_pkg::*;

    `include "scanout_expect.svh"

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int OUT_LATENCY     = 3;
    localparam int FRAME_POSITIONS = H_TOTAL * V_TOTAL;
    localparam int NUM_TESTS       = 10;
    localparam int ROW_SLACK       = 100;

    typedef struct {
        int delay;
        int enable;
        int odd;
        int intensity;
        int count;
        int restart;
    } test_row_t;

    // delay, enable, odd, intensity, positions, second start (-1 none)
    test_row_t tests [NUM_TESTS] = '{
        '{ 5, 0, 0, 0, FRAME_POSITIONS + 2 * H_TOTAL + 100, -1},
        '{ 3, 1, 0, 0, 4 * H_TOTAL, -1},
        '{ 4, 1, 0, 1, 4 * H_TOTAL, -1},
        '{ 6, 1, 0, 2, 4 * H_TOTAL, -1},
        '{ 8, 1, 0, 3, 4 * H_TOTAL, -1},
        '{ 3, 1, 1, 0, 4 * H_TOTAL, -1},
        '{ 5, 1, 1, 1, 4 * H_TOTAL, -1},
        '{ 7, 1, 1, 2, 4 * H_TOTAL, -1},
        '{10, 1, 1, 3, 4 * H_TOTAL, -1},
        '{ 4, 1, 1, 1, 4 * H_TOTAL, 2 * H_TOTAL + 300}
    };

    logic                   clock;
    logic                   reset;
    logic                   start;
    logic                   scanline_enable;
    logic                   scanline_odd;
    logic [INTENSITY_W-1:0] scanline_intensity;
    logic [ADDR_W-1:0]      rdaddr;
    logic [PIXEL_W-1:0]     rddata;
    logic [PIXEL_W-1:0]     video_out;
    logic                   hsync;
    logic                   vsync;
    logic                   draw_area;

    logic [PIXEL_W-1:0] ram [SRC_WORDS];
    logic [PIXEL_W-1:0] ref_words [SRC_WORDS];
    integer             seed = 91;
    longint             checks_done = 0;

    framebuffer_scanout dut (
        .clock              (clock),
        .reset              (reset),
        .start              (start),
        .scanline_enable    (scanline_enable),
        .scanline_odd       (scanline_odd),
        .scanline_intensity (scanline_intensity),
        .rdaddr             (rdaddr),
        .rddata             (rddata),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // external ram, one cycle read latency
    always @(posedge clock) begin
        rddata <= ram[rdaddr];
    end

    // random words mixed with the full address
    initial begin : fill_ram
        logic [PIXEL_W-1:0] word;
        for (int a = 0; a < SRC_WORDS; a++) begin
            word = PIXEL_W'($random(seed)) ^ PIXEL_W'(a * 40503);
            ram[a] = word;
            ref_words[a] = word;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        checks_done++;
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_idle(input bit with_addr);
        if (with_addr) begin
            check_value("rdaddr", rdaddr, 0);
        end
        check_value("video_out", video_out, 0);
        check_value("draw_area", draw_area, 0);
        check_value("hsync", hsync, !HSYNC_ON);
        check_value("vsync", vsync, !VSYNC_ON);
    endtask

    //////////////////////////////////////////////////////////////////////
    // k counts clock edges after the edge that took start
    //////////////////////////////////////////////////////////////////////
    task automatic check_cycle(input int t, input int k);
        int x;
        int y;
        int addr;
        if (k >= 1) begin
            check_value("rdaddr", rdaddr, expect_addr(raster_x(k - 1), raster_y(k - 1)));
        end else begin
            check_value("rdaddr", rdaddr, 0);
        end
        if (k < OUT_LATENCY) begin
            check_idle(1'b0);
        end else begin
            x = raster_x(k - OUT_LATENCY);
            y = raster_y(k - OUT_LATENCY);
            addr = expect_addr(x, y);
            check_value("video_out", video_out, expect_pixel(ref_words[addr], x, y,
                tests[t].enable, tests[t].odd, tests[t].intensity));
            check_value("draw_area", draw_area, in_draw(x, y));
            check_value("hsync", hsync, expect_hsync(x));
            check_value("vsync", vsync, expect_vsync(y));
        end
    endtask

    task automatic run_test(input int t);
        @(negedge clock);
        reset = 1'b1;
        start = 1'b0;
        scanline_enable = (tests[t].enable != 0);
        scanline_odd = (tests[t].odd != 0);
        scanline_intensity = INTENSITY_W'(tests[t].intensity);
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        // idle until start
        repeat (tests[t].delay) begin
            @(negedge clock);
            check_idle(1'b1);
        end
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        for (int k = 0; k < tests[t].count + OUT_LATENCY; k++) begin
            check_cycle(t, k);
            // repeated start while running
            start = (k == tests[t].restart);
            @(negedge clock);
        end
        start = 1'b0;
    endtask

    initial begin : main
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        scanline_enable = 1'b0;
        scanline_odd = 1'b0;
        scanline_intensity = '0;
        rddata = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        if (checks_done > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("no checks were run");
            $display("Simulation failed");
            $fatal(1, "empty run");
        end
    end

    initial begin : watchdog
        longint limit;
        limit = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += tests[t].count + ROW_SLACK;
        end
        #(limit * CLK_PERIOD);
        $display("run timed out after %0d cycles", limit);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: project.f
+incdir+dv
rtl/video_timing_pkg.sv
rtl/pixel_pkg.sv
rtl/raster_if.sv
rtl/video_ctrl_if.sv
rtl/raster_counter.sv
rtl/fb_address_gen.sv
rtl/sync_gen.sv
rtl/scanline_shader.sv
rtl/framebuffer_scanout.sv
dv/tb_framebuffer_scanout.sv

// File: rtl/fb_address_gen.sv
/*
 * source buffer address generator
 * maps each raster position to a 320x240 word, two clocks per pixel
 * and two lines per source line, one cycle behind the raster counter
 */
`timescale 1ns/1ps

module fb_address_gen (
    input  logic                        clock,
    input  logic                        reset,
    raster_if.sink                      raster_a,
    raster_if.source                    raster_b,
    output logic [pixel_pkg::ADDR_W-1:0] rdaddr
);
    import video_timing_pkg::*;
    import pixel_pkg::*;

    logic [$clog2(PIXEL_REPEAT)-1:0] rep_cnt;
    logic [$clog2(SRC_WIDTH)-1:0]    col;
    logic [$clog2(LINE_REPEAT)-1:0]  line_rep;
    logic [ADDR_W-1:0]               line_base;

    //////////////////////////////////////////////////////////////////////
    // counters hold the state for the position on raster_a
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rep_cnt   <= '0;
            col       <= '0;
            line_rep  <= '0;
            line_base <= '0;
        end else if (raster_a.running) begin
            if (raster_a.x == COORD_W'(H_TOTAL - 1)) begin
                rep_cnt <= '0;
                col     <= '0;
                if (raster_a.y == COORD_W'(V_TOTAL - 1)) begin
                    line_rep  <= '0;
                    line_base <= '0;
                end else if (raster_a.y < V_VISIBLE) begin
                    // next source line after LINE_REPEAT output lines
                    if (int'(line_rep) == LINE_REPEAT - 1) begin
                        line_rep  <= '0;
                        line_base <= line_base + ADDR_W'(SRC_WIDTH);
                    end else begin
                        line_rep <= line_rep + 1'b1;
                    end
                end
            end else if (raster_a.active) begin
                if (int'(rep_cnt) == PIXEL_REPEAT - 1) begin
                    rep_cnt <= '0;
                    col     <= col + 1'b1;
                end else begin
                    rep_cnt <= rep_cnt + 1'b1;
                end
            end
        end
    end

    // address 0 whenever the position is blank
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rdaddr           <= '0;
            raster_b.active  <= 1'b0;
            raster_b.running <= 1'b0;
        end else begin
            rdaddr           <= raster_a.active ? line_base + ADDR_W'(col) : '0;
            raster_b.active  <= raster_a.active;
            raster_b.running <= raster_a.running;
        end
    end

    always_ff @(posedge clock) begin
        raster_b.x <= raster_a.x;
        raster_b.y <= raster_a.y;
    end

    a_addr_in_buffer: assert property (@(posedge clock) disable iff (reset)
        rdaddr < SRC_WORDS);

endmodule

// File: rtl/framebuffer_scanout.sv
/*
 * framebuffer scan-out engine
 * 320x240 buffer shown as 640x480 on an 800x525 raster, four stage
 * pipeline with three clocks from start to the first output pixel
 */
`timescale 1ns/1ps

module framebuffer_scanout (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             start,
    input  logic                             scanline_enable,
    input  logic                             scanline_odd,
    input  logic [pixel_pkg::INTENSITY_W-1:0] scanline_intensity,
    output logic [pixel_pkg::ADDR_W-1:0]      rdaddr,
    input  logic [pixel_pkg::PIXEL_W-1:0]     rddata,
    output logic [pixel_pkg::PIXEL_W-1:0]     video_out,
    output logic                             hsync,
    output logic                             vsync,
    output logic                             draw_area
);

    // raster_a feeds address generation, raster_b the sync stage
    raster_if     raster_a ();
    raster_if     raster_b ();
    video_ctrl_if ctrl ();

    raster_counter u_raster_counter (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .raster (raster_a)
    );

    fb_address_gen u_fb_address_gen (
        .clock    (clock),
        .reset    (reset),
        .raster_a (raster_a),
        .raster_b (raster_b),
        .rdaddr   (rdaddr)
    );

    // ram word for a position shows up with this stage's output
    sync_gen u_sync_gen (
        .clock           (clock),
        .reset           (reset),
        .raster          (raster_b),
        .ctrl            (ctrl),
        .scanline_enable (scanline_enable),
        .scanline_odd    (scanline_odd)
    );

    scanline_shader u_scanline_shader (
        .clock              (clock),
        .reset              (reset),
        .ctrl               (ctrl),
        .rddata             (rddata),
        .scanline_intensity (scanline_intensity),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area)
    );

endmodule

// File: rtl/pixel_pkg.sv
/*
 * pixel and source buffer constants
 * rgb word layout, 320x240 source buffer and the scanline intensity width
 */
package pixel_pkg;

    // rgb888, red in the top byte, blue in the bottom byte
    localparam int PIXEL_W   = 24;
    localparam int CHANNEL_W = 8;

    // source buffer geometry
    localparam int SRC_WIDTH  = 320;
    localparam int SRC_HEIGHT = 240;
    localparam int SRC_WORDS  = SRC_WIDTH * SRC_HEIGHT;
    localparam int ADDR_W     = 17;

    // upscale factors to reach 640x480
    localparam int PIXEL_REPEAT = 2;
    localparam int LINE_REPEAT  = 2;

    // right shift applied to darkened lines
    localparam int INTENSITY_W = 2;

endpackage

// File: rtl/raster_counter.sv
/*
 * raster position counter
 * waits for start, then walks the 800x525 raster forever
 */
`timescale 1ns/1ps

module raster_counter (
    input  logic     clock,
    input  logic     reset,
    input  logic     start,
    raster_if.source raster
);
    import video_timing_pkg::*;

    logic               running;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               line_end;
    logic               frame_end;

    assign line_end  = (x == COORD_W'(H_TOTAL - 1));
    assign frame_end = (y == COORD_W'(V_TOTAL - 1));

    // sticky until reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= running | start;
        end
    end

    // position 0 sits on the counters until the first running edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x <= '0;
            y <= '0;
        end else if (running) begin
            if (line_end) begin
                x <= '0;
                y <= frame_end ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    assign raster.x       = x;
    assign raster.y       = y;
    assign raster.running = running;
    assign raster.active  = running && (x < H_VISIBLE) && (y < V_VISIBLE);

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    a_in_raster: assert property (@(posedge clock) disable iff (reset)
        (x < H_TOTAL) && (y < V_TOTAL));

endmodule

// File: rtl/raster_if.sv
/*
 * raster position bundle
 * one x/y position per clock with its visible flag and the running flag
 */
`timescale 1ns/1ps

interface raster_if;
    import video_timing_pkg::*;

    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    // inside the 640x480 window
    logic               active;
    logic               running;

    modport source (
        output x, y, active, running
    );

    modport sink (
        input x, y, active, running
    );

endinterface

// File: rtl/scanline_shader.sv
/*
 * output stage
 * blanks pixels outside the draw area and darkens scanline rows
 */
`timescale 1ns/1ps

module scanline_shader (
    input  logic                             clock,
    input  logic                             reset,
    video_ctrl_if.sink                       ctrl,
    input  logic [pixel_pkg::PIXEL_W-1:0]     rddata,
    input  logic [pixel_pkg::INTENSITY_W-1:0] scanline_intensity,
    output logic [pixel_pkg::PIXEL_W-1:0]     video_out,
    output logic                             hsync,
    output logic                             vsync,
    output logic                             draw_area
);
    import video_timing_pkg::*;
    import pixel_pkg::*;

    logic [PIXEL_W-1:0] shaded;

    // every channel gets the same shift
    always_comb begin
        shaded = rddata;
        if (ctrl.darken) begin
            for (int c = 0; c < PIXEL_W / CHANNEL_W; c++) begin
                shaded[c*CHANNEL_W +: CHANNEL_W] =
                    rddata[c*CHANNEL_W +: CHANNEL_W] >> scanline_intensity;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            hsync     <= ~HSYNC_ON;
            vsync     <= ~VSYNC_ON;
            draw_area <= 1'b0;
        end else begin
            video_out <= (ctrl.running && ctrl.draw_area) ? shaded : '0;
            hsync     <= ctrl.hsync;
            vsync     <= ctrl.vsync;
            draw_area <= ctrl.draw_area;
        end
    end

    a_blank_outside: assert property (@(posedge clock) disable iff (reset)
        !draw_area |-> video_out == '0);

endmodule

// File: rtl/sync_gen.sv
/*
 * sync and control generator
 * hsync, vsync, draw area and scanline flag per position, registered so
 * they line up with the ram word for the same position
 */
`timescale 1ns/1ps

module sync_gen (
    input  logic         clock,
    input  logic         reset,
    raster_if.sink       raster,
    video_ctrl_if.source ctrl,
    input  logic         scanline_enable,
    input  logic         scanline_odd
);
    import video_timing_pkg::*;

    logic in_hsync;
    logic in_vsync;
    logic on_scanline;

    //////////////////////////////////////////////////////////////////////
    // window decode on the incoming position
    //////////////////////////////////////////////////////////////////////
    assign in_hsync = (raster.x >= H_SYNC_START)
                   && (raster.x < H_SYNC_START + H_SYNC_WIDTH);

    // vsync covers whole lines
    assign in_vsync = (raster.y >= V_SYNC_START)
                   && (raster.y < V_SYNC_START + V_SYNC_WIDTH);

    // odd selects lines 1, 3, 5 and so on
    assign on_scanline = scanline_enable && (raster.y[0] == scanline_odd);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ctrl.hsync     <= ~HSYNC_ON;
            ctrl.vsync     <= ~VSYNC_ON;
            ctrl.draw_area <= 1'b0;
            ctrl.darken    <= 1'b0;
            ctrl.running   <= 1'b0;
        end else begin
            ctrl.running <= raster.running;
            if (raster.running) begin
                ctrl.hsync     <= in_hsync ? HSYNC_ON : ~HSYNC_ON;
                ctrl.vsync     <= in_vsync ? VSYNC_ON : ~VSYNC_ON;
                ctrl.draw_area <= raster.active;
                ctrl.darken    <= on_scanline;
            end else begin
                // idle, keep everything inactive
                ctrl.hsync     <= ~HSYNC_ON;
                ctrl.vsync     <= ~VSYNC_ON;
                ctrl.draw_area <= 1'b0;
                ctrl.darken    <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/video_ctrl_if.sv
/*
 * per-pixel video control
 * sync levels, draw area and scanline darkening for one raster position
 */
`timescale 1ns/1ps

interface video_ctrl_if;

    logic hsync;
    logic vsync;
    logic draw_area;
    // this line gets the scanline shading
    logic darken;
    logic running;

    modport source (
        output hsync, vsync, draw_area, darken, running
    );

    modport sink (
        input hsync, vsync, draw_area, darken, running
    );

endinterface

// File: rtl/video_timing_pkg.sv
/*
 * video timing constants
 * fixed 640x480 mode on an 800x525 raster with negative sync pulses
 */
package video_timing_pkg;

    // wide enough for both raster totals
    localparam int COORD_W = 10;

    //////////////////////////////////////////////////////////////////////
    // horizontal, in pixel clocks
    //////////////////////////////////////////////////////////////////////
    localparam int H_VISIBLE    = 640;
    localparam int H_TOTAL      = 800;
    localparam int H_SYNC_START = 656;
    localparam int H_SYNC_WIDTH = 96;

    //////////////////////////////////////////////////////////////////////
    // vertical, in whole lines
    //////////////////////////////////////////////////////////////////////
    localparam int V_VISIBLE    = 480;
    localparam int V_TOTAL      = 525;
    localparam int V_SYNC_START = 490;
    localparam int V_SYNC_WIDTH = 2;

    // active sync levels
    localparam logic HSYNC_ON = 1'b0;
    localparam logic VSYNC_ON = 1'b0;

endpackage
